// ==== src/mdu_config.svh ====
/* mdu configuration
   data, rob index and physical register widths */

`ifndef MDU_CONFIG_SVH
`define MDU_CONFIG_SVH

// datapath width, the arithmetic units assume 32
`define MDU_XLEN   32

// tag widths toward rob and register file
`define MDU_ROB_W  6
`define MDU_PREG_W 6

`endif

// ==== src/mdu_pkg.sv ====
/* mdu shared types
   opcodes, pipe states and the packed issue, writeback and unit structs */

`include "mdu_config.svh"

package mdu_pkg;

  typedef enum logic [1:0] {
    MDU_MUL  = 2'd0,  // low word of product
    MDU_MULH = 2'd1,  // high word of product
    MDU_DIV  = 2'd2,
    MDU_MOD  = 2'd3
  } mdu_op_e;

  typedef enum logic {
    IDLE = 1'b0,  // stage 1 empty or result ready
    WAIT = 1'b1   // unit busy
  } mdu_state_e;

  // ================================================
  // issue and writeback
  // ================================================
  typedef struct packed {
    logic                   valid;
    mdu_op_e                op;
    logic                   is_signed;
    logic [`MDU_XLEN-1:0]   src0;
    logic [`MDU_XLEN-1:0]   src1;
    logic                   pdest_valid;
    logic [`MDU_PREG_W-1:0] pdest;
    logic [`MDU_ROB_W-1:0]  rob_idx;
  } mdu_exe_t;

  typedef struct packed {
    logic                   valid;
    logic                   we;     // from pdest_valid
    logic [`MDU_PREG_W-1:0] pdest;
    logic [`MDU_XLEN-1:0]   wdata;
    logic [`MDU_ROB_W-1:0]  rob_idx;
  } mdu_wb_t;

  // ================================================
  // unit side
  // ================================================
  typedef struct packed {
    logic                 valid;        // start pulse
    logic                 is_signed;
    logic [`MDU_XLEN-1:0] multiplicand;
    logic [`MDU_XLEN-1:0] multiplier;
  } mult_req_t;

  typedef struct packed {
    logic                 valid;   // one cycle
    logic                 ready;   // unit idle
    logic [`MDU_XLEN-1:0] res_lo;
    logic [`MDU_XLEN-1:0] res_hi;
  } mult_rsp_t;

  typedef struct packed {
    logic                 valid;
    logic                 is_signed;
    logic [`MDU_XLEN-1:0] dividend;
    logic [`MDU_XLEN-1:0] divisor;
  } div_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 ready;
    logic [`MDU_XLEN-1:0] quotient;
    logic [`MDU_XLEN-1:0] remainder;
  } div_rsp_t;

endpackage

// ==== src/mdu_multiplier.sv ====
/* two stage 32x32 multiplier
   signed or unsigned, returns low and high product words */

`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_multiplier (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  input  mdu_pkg::mult_req_t req_i,
  output mdu_pkg::mult_rsp_t rsp_o
);

  logic                       v1_q;   // operands held
  logic                       v2_q;   // product held
  logic                       start;
  logic signed [`MDU_XLEN:0]  a_q;    // 33 bit, extended
  logic signed [`MDU_XLEN:0]  b_q;
  logic signed [2*`MDU_XLEN+1:0] full;
  logic [2*`MDU_XLEN-1:0]     prod_q;

  assign start = req_i.valid & ~v1_q & ~v2_q;  // only taken while idle
  assign full  = a_q * b_q;

  // ================================================
  // stage valids
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else if (flush_i) begin
      v1_q <= 1'b0;  // drop both stages
      v2_q <= 1'b0;
    end else begin
      v1_q <= start;
      v2_q <= v1_q;  // one cycle pulse
    end
  end

  // operand and product registers
  always_ff @(posedge clk) begin
    if (start) begin
      a_q <= {req_i.is_signed & req_i.multiplicand[`MDU_XLEN-1], req_i.multiplicand};
      b_q <= {req_i.is_signed & req_i.multiplier[`MDU_XLEN-1], req_i.multiplier};
    end
    if (v1_q) prod_q <= full[2*`MDU_XLEN-1:0];  // upper bits are sign copies
  end

  always_comb begin
    rsp_o.valid  = v2_q;
    rsp_o.ready  = ~v1_q & ~v2_q;
    rsp_o.res_lo = prod_q[`MDU_XLEN-1:0];
    rsp_o.res_hi = prod_q[2*`MDU_XLEN-1:`MDU_XLEN];
  end

endmodule

// ==== src/mdu_divider.sv ====
/* radix-2 restoring divider
   works on magnitudes, fixes signs and corner cases in a final cycle */

`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_divider (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  input  mdu_pkg::div_req_t req_i,
  output mdu_pkg::div_rsp_t rsp_o
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,   // one quotient bit per cycle
    FIX    // signs and corner results
  } div_state_e;

  localparam logic [`MDU_XLEN-1:0] MOST_NEG = {1'b1, {(`MDU_XLEN-1){1'b0}}};

  div_state_e           state_q;
  logic [4:0]           cnt_q;      // iterations left
  logic                 valid_q;
  logic                 start;
  logic                 a_neg, b_neg;
  logic [`MDU_XLEN-1:0] a_abs, b_abs;
  logic [`MDU_XLEN-1:0] rem_q;      // partial remainder
  logic [`MDU_XLEN-1:0] quo_q;      // dividend bits shift out, quotient bits in
  logic [`MDU_XLEN-1:0] dvs_q;      // divisor magnitude
  logic [`MDU_XLEN-1:0] dvd_q;      // original dividend
  logic                 neg_quo_q, neg_rem_q, div0_q, ovf_q;
  logic [`MDU_XLEN:0]   rem_sh;
  logic [`MDU_XLEN:0]   diff;
  logic [`MDU_XLEN-1:0] quo_out_q, rem_out_q;

  always_comb begin
    start  = (state_q == IDLE) & req_i.valid;
    a_neg  = req_i.is_signed & req_i.dividend[`MDU_XLEN-1];
    b_neg  = req_i.is_signed & req_i.divisor[`MDU_XLEN-1];
    a_abs  = a_neg ? -req_i.dividend : req_i.dividend;
    b_abs  = b_neg ? -req_i.divisor : req_i.divisor;
    rem_sh = {rem_q, quo_q[`MDU_XLEN-1]};  // shift in next dividend bit
    diff   = rem_sh - {1'b0, dvs_q};        // msb set means restore
  end

  // ================================================
  // control
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else if (flush_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        IDLE: if (start) begin
          state_q <= RUN;
          cnt_q   <= 5'd31;
        end
        RUN: begin
          cnt_q <= cnt_q - 5'd1;
          if (cnt_q == 5'd0) state_q <= FIX;
        end
        FIX: begin
          state_q <= IDLE;
          valid_q <= 1'b1;  // result pulse
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (start) begin
      rem_q     <= '0;
      quo_q     <= a_abs;
      dvs_q     <= b_abs;
      dvd_q     <= req_i.dividend;
      neg_quo_q <= a_neg ^ b_neg;
      neg_rem_q <= a_neg;  // remainder follows dividend
      div0_q    <= (req_i.divisor == '0);
      ovf_q     <= req_i.is_signed & (req_i.dividend == MOST_NEG) & (&req_i.divisor);
    end
    if (state_q == RUN) begin
      if (!diff[`MDU_XLEN]) begin
        rem_q <= diff[`MDU_XLEN-1:0];
        quo_q <= {quo_q[`MDU_XLEN-2:0], 1'b1};
      end else begin
        rem_q <= rem_sh[`MDU_XLEN-1:0];
        quo_q <= {quo_q[`MDU_XLEN-2:0], 1'b0};
      end
    end
    if (state_q == FIX) begin
      if (div0_q) begin
        quo_out_q <= '1;
        rem_out_q <= dvd_q;
      end else if (ovf_q) begin
        quo_out_q <= dvd_q;
        rem_out_q <= '0;
      end else begin
        quo_out_q <= neg_quo_q ? -quo_q : quo_q;
        rem_out_q <= neg_rem_q ? -rem_q : rem_q;
      end
    end
  end

  always_comb begin
    rsp_o.valid     = valid_q;
    rsp_o.ready     = (state_q == IDLE);
    rsp_o.quotient  = quo_out_q;
    rsp_o.remainder = rem_out_q;
  end

endmodule

// ==== src/mdu_pipe.sv ====
/* mdu issue pipe
   holds one op in stage 1, starts a unit and presents the result for writeback */

`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_pipe (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  input  mdu_pkg::mdu_exe_t  exe_i,
  output logic               ready_o,
  output mdu_pkg::mdu_wb_t   wb_o,
  input  logic               wb_ready_i,
  output mdu_pkg::mult_req_t mult_req_o,
  input  mdu_pkg::mult_rsp_t mult_rsp_i,
  output mdu_pkg::div_req_t  div_req_o,
  input  mdu_pkg::div_rsp_t  div_rsp_i
);

  mdu_pkg::mdu_state_e  state_q;
  mdu_pkg::mdu_exe_t    s1_q;         // op payload, valid kept apart
  logic                 s1_valid_q;
  logic                 start_q;      // first WAIT cycle
  logic                 res_valid_q;
  logic [`MDU_XLEN-1:0] res_q;
  logic                 is_mul;
  logic                 rsp_pulse;
  logic                 wb_fire;
  logic                 accept;

  // ================================================
  // handshakes
  // ================================================
  always_comb begin
    is_mul    = (s1_q.op == mdu_pkg::MDU_MUL) | (s1_q.op == mdu_pkg::MDU_MULH);
    rsp_pulse = (state_q == mdu_pkg::WAIT) & (is_mul ? mult_rsp_i.valid : div_rsp_i.valid);

    wb_o.valid   = s1_valid_q & res_valid_q;
    wb_o.we      = s1_q.pdest_valid;
    wb_o.pdest   = s1_q.pdest;
    wb_o.wdata   = res_q;
    wb_o.rob_idx = s1_q.rob_idx;
    wb_fire      = wb_o.valid & wb_ready_i;

    // empty, or drained this edge with both units idle
    ready_o = ~flush_i &
              (~s1_valid_q | (wb_fire & mult_rsp_i.ready & div_rsp_i.ready));
    accept  = exe_i.valid & ready_o;
  end

  // request building, operands straight from stage 1
  always_comb begin
    mult_req_o.valid        = start_q & is_mul;
    mult_req_o.is_signed    = s1_q.is_signed;
    mult_req_o.multiplicand = s1_q.src0;
    mult_req_o.multiplier   = s1_q.src1;

    div_req_o.valid     = start_q & ~is_mul;
    div_req_o.is_signed = s1_q.is_signed;
    div_req_o.dividend  = s1_q.src0;
    div_req_o.divisor   = s1_q.src1;
  end

  // ================================================
  // control state
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= mdu_pkg::IDLE;
      s1_valid_q  <= 1'b0;
      start_q     <= 1'b0;
      res_valid_q <= 1'b0;
    end else if (flush_i) begin
      state_q     <= mdu_pkg::IDLE;  // cancel op in flight
      s1_valid_q  <= 1'b0;
      start_q     <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      start_q <= accept;
      if (accept) begin
        s1_valid_q  <= 1'b1;
        res_valid_q <= 1'b0;
        state_q     <= mdu_pkg::WAIT;
      end else begin
        if (wb_fire) begin
          s1_valid_q  <= 1'b0;
          res_valid_q <= 1'b0;
        end
        if (rsp_pulse) begin
          state_q     <= mdu_pkg::IDLE;
          res_valid_q <= 1'b1;  // held until writeback
        end
      end
    end
  end

  // stage 1 payload and result latch
  always_ff @(posedge clk) begin
    if (accept) s1_q <= exe_i;
    if (rsp_pulse) begin
      case (s1_q.op)
        mdu_pkg::MDU_MUL:  res_q <= mult_rsp_i.res_lo;
        mdu_pkg::MDU_MULH: res_q <= mult_rsp_i.res_hi;
        mdu_pkg::MDU_DIV:  res_q <= div_rsp_i.quotient;
        default:           res_q <= div_rsp_i.remainder;
      endcase
    end
  end

endmodule

// ==== src/mdu_top.sv ====
/* mdu top level
   pipe next to the multiplier and divider */

`timescale 1ns/1ps

module mdu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  input  mdu_pkg::mdu_exe_t exe_i,
  output logic              ready_o,
  output mdu_pkg::mdu_wb_t  wb_o,
  input  logic              wb_ready_i
);

  mdu_pkg::mult_req_t mult_req;
  mdu_pkg::mult_rsp_t mult_rsp;
  mdu_pkg::div_req_t  div_req;
  mdu_pkg::div_rsp_t  div_rsp;

  mdu_pipe u_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .exe_i      (exe_i),
    .ready_o    (ready_o),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i),
    .mult_req_o (mult_req),
    .mult_rsp_i (mult_rsp),
    .div_req_o  (div_req),
    .div_rsp_i  (div_rsp)
  );

  // flush also empties both units
  mdu_multiplier u_mult (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .req_i   (mult_req),
    .rsp_o   (mult_rsp)
  );

  mdu_divider u_div (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .req_i   (div_req),
    .rsp_o   (div_rsp)
  );

endmodule

// ==== bench/mdu_sva.sv ====
/* mdu pipe assertions
   handshake stability and state rules, bound into every mdu_pipe */

`timescale 1ns/1ps

module mdu_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                flush_i,
  input mdu_pkg::mdu_state_e state_q,
  input logic                ready_o,
  input mdu_pkg::mdu_wb_t    wb_o,
  input logic                wb_ready_i,
  input mdu_pkg::mult_req_t  mult_req_o,
  input mdu_pkg::div_req_t   div_req_o
);

  // result must hold while writeback stalls
  wb_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_o.valid && !wb_ready_i && !flush_i) |=> $stable(wb_o))
    else $error("wb_o changed while stalled");

  // start pulses only come out of WAIT
  no_req_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == mdu_pkg::IDLE) |-> !(mult_req_o.valid || div_req_o.valid))
    else $error("unit request raised in IDLE");

  no_ready_wait_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == mdu_pkg::WAIT) |-> !ready_o)
    else $error("ready_o high in WAIT");

endmodule

bind mdu_pipe mdu_sva u_sva (.*);

// ==== bench/mdu_checker.sv ====
/* mdu scoreboard
   predicts results on accept, compares writebacks, ready, latency and stalls */

`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  input  mdu_pkg::mdu_exe_t exe_i,
  input  logic              ready_o,
  input  mdu_pkg::mdu_wb_t  wb_o,
  input  logic              wb_ready_i,
  output int                err_cnt_o,
  output int                test_cnt_o,
  output int                pending_o
);

  mdu_pkg::mdu_wb_t exp_q[$];   // expected writebacks, in order
  mdu_pkg::mdu_op_e op_q[$];
  int               stamp_q[$];  // accept cycle
  int               cycle;
  logic             seen_head;   // head already checked for latency
  logic             hold_q;
  mdu_pkg::mdu_wb_t prev_wb;

  // reference arithmetic from the op rules
  function automatic logic [`MDU_XLEN-1:0] calc(input mdu_pkg::mdu_op_e op, input logic sgn,
                                                input logic [31:0] a, input logic [31:0] b);
    logic [63:0]        ea;
    logic [63:0]        eb;
    logic [63:0]        prod;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    ea = sgn ? {{32{a[31]}}, a} : {32'h0, a};
    eb = sgn ? {{32{b[31]}}, b} : {32'h0, b};
    prod = ea * eb;
    sa = a;
    sb = b;
    case (op)
      mdu_pkg::MDU_MUL:  return prod[31:0];
      mdu_pkg::MDU_MULH: return prod[63:32];
      default: begin
        if (b == 32'h0) return (op == mdu_pkg::MDU_DIV) ? 32'hffff_ffff : a;
        if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff)
          return (op == mdu_pkg::MDU_DIV) ? a : 32'h0;
        if (sgn) return (op == mdu_pkg::MDU_DIV) ? sa / sb : sa % sb;  // truncating
        return (op == mdu_pkg::MDU_DIV) ? a / b : a % b;
      end
    endcase
  endfunction

  assign pending_o = exp_q.size();

  always @(posedge clk or negedge rst_n) begin
    mdu_pkg::mdu_wb_t e;
    mdu_pkg::mdu_op_e op;
    int               lat;
    int               want;
    logic             exp_rdy;
    if (!rst_n) begin
      cycle      = 0;
      err_cnt_o  = 0;
      test_cnt_o = 0;
      seen_head  = 1'b0;
      hold_q     = 1'b0;
      exp_q.delete();
      op_q.delete();
      stamp_q.delete();
    end else begin
      // stall rules
      if (hold_q && wb_o != prev_wb && !flush_i) begin
        $display("error t=%0t wb_o got %h expected %h", $time, wb_o, prev_wb);
        err_cnt_o++;
      end
      // one op in stage 1, free once empty or on its writeback edge
      exp_rdy = (exp_q.size() == 0) || (wb_o.valid && wb_ready_i);
      if (!flush_i && ready_o !== exp_rdy) begin
        $display("error t=%0t ready_o got %b expected %b", $time, ready_o, exp_rdy);
        err_cnt_o++;
      end
      hold_q  = wb_o.valid && !wb_ready_i && !flush_i;
      prev_wb = wb_o;

      if (flush_i) begin
        if (exp_q.size() != 0) $display("flush at t=%0t drops %0d op", $time, exp_q.size());
        exp_q.delete();
        op_q.delete();
        stamp_q.delete();
        seen_head = 1'b0;
      end else begin
        if (wb_o.valid && exp_q.size() == 0) begin
          $display("writeback at t=%0t with no operation pending", $time);
          err_cnt_o++;
        end else if (wb_o.valid) begin
          // latency on first sight of the result
          if (!seen_head) begin
            lat  = cycle - stamp_q[0];
            want = (op_q[0] == mdu_pkg::MDU_MUL || op_q[0] == mdu_pkg::MDU_MULH) ? 4 : 36;
            if (lat != want) begin
              $display("error t=%0t latency got %0d expected %0d", $time, lat, want);
              err_cnt_o++;
            end
            seen_head = 1'b1;
          end
          if (wb_ready_i) begin
            e  = exp_q.pop_front();
            op = op_q.pop_front();
            void'(stamp_q.pop_front());
            seen_head = 1'b0;
            test_cnt_o++;
            if (wb_o.wdata !== e.wdata) begin
              $display("error t=%0t wb_o.wdata got %h expected %h", $time, wb_o.wdata, e.wdata);
              err_cnt_o++;
            end
            if (wb_o.rob_idx !== e.rob_idx) begin
              $display("error t=%0t wb_o.rob_idx got %0d expected %0d",
                       $time, wb_o.rob_idx, e.rob_idx);
              err_cnt_o++;
            end
            if (wb_o.pdest !== e.pdest) begin
              $display("error t=%0t wb_o.pdest got %0d expected %0d",
                       $time, wb_o.pdest, e.pdest);
              err_cnt_o++;
            end
            if (wb_o.we !== e.we) begin
              $display("error t=%0t wb_o.we got %b expected %b", $time, wb_o.we, e.we);
              err_cnt_o++;
            end
            $display("test %0d %s rob %0d done", test_cnt_o, op.name(), e.rob_idx);
          end
        end
        // accept after pop, back-to-back case
        if (exe_i.valid && ready_o) begin
          e.valid   = 1'b1;
          e.we      = exe_i.pdest_valid;
          e.pdest   = exe_i.pdest;
          e.rob_idx = exe_i.rob_idx;
          e.wdata   = calc(exe_i.op, exe_i.is_signed, exe_i.src0, exe_i.src1);
          exp_q.push_back(e);
          op_q.push_back(exe_i.op);
          stamp_q.push_back(cycle);
        end
      end
      cycle++;
    end
  end

endmodule

// ==== bench/mdu_tb.sv ====
/* mdu testbench
   table driven ops, writeback stalls, flush during divide, summary */

`timescale 1ns/1ps

module mdu_tb;

  typedef struct packed {
    mdu_pkg::mdu_op_e op;
    logic             sgn;
    logic [31:0]      src0;
    logic [31:0]      src1;
    logic             pv;     // pdest_valid
    logic [7:0]       stall;  // writeback stall cycles
  } stim_t;

  logic              clk;
  logic              rst_n;
  logic              flush_i;
  mdu_pkg::mdu_exe_t exe_i;
  logic              ready_o;
  mdu_pkg::mdu_wb_t  wb_o;
  logic              wb_ready_i;
  int                err_cnt;
  int                test_cnt;
  int                pending;
  stim_t             table_q[$];
  int                seed;
  int                rob;
  logic              aborted;

  mdu_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .exe_i      (exe_i),
    .ready_o    (ready_o),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i)
  );

  mdu_checker u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .exe_i      (exe_i),
    .ready_o    (ready_o),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i),
    .err_cnt_o  (err_cnt),
    .test_cnt_o (test_cnt),
    .pending_o  (pending)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns
  end

  task automatic add_op(input mdu_pkg::mdu_op_e op, input logic sgn, input logic [31:0] a,
                        input logic [31:0] b, input logic pv, input int stall);
    stim_t s;
    s.op    = op;
    s.sgn   = sgn;
    s.src0  = a;
    s.src1  = b;
    s.pv    = pv;
    s.stall = stall[7:0];
    table_q.push_back(s);
  endtask

  // present one op and wait for the accept edge
  task automatic issue(input stim_t s);
    int n;
    @(negedge clk);
    exe_i.valid       = 1'b1;
    exe_i.op          = s.op;
    exe_i.is_signed   = s.sgn;
    exe_i.src0        = s.src0;
    exe_i.src1        = s.src1;
    exe_i.pdest_valid = s.pv;
    exe_i.pdest       = rob[5:0] + 6'd1;
    exe_i.rob_idx     = rob[5:0];
    rob++;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(ready_o && exe_i.valid) && n < 100);
    if (n >= 100) begin
      $display("timeout: operation for rob %0d was never accepted", exe_i.rob_idx);
      aborted = 1'b1;
    end
    @(negedge clk);
    exe_i.valid = 1'b0;
    if (s.stall != 0) wb_ready_i = 1'b0;
  endtask

  // hold writeback off for some cycles once the result shows
  task automatic stall_wb(input int cycles);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!wb_o.valid && n < 100);
    if (n >= 100) begin
      $display("timeout: stalled result never became valid");
      aborted = 1'b1;
    end
    repeat (cycles) @(posedge clk);
    @(negedge clk);
    wb_ready_i = 1'b1;
  endtask

  // ================================================
  // stimulus
  // ================================================
  initial begin
    int n;
    rst_n      = 1'b0;
    flush_i    = 1'b0;
    exe_i      = '0;
    wb_ready_i = 1'b1;
    seed       = 32'h9b95_9474;
    rob        = 0;
    aborted    = 1'b0;

    add_op(mdu_pkg::MDU_MUL,  1'b0, 32'd7, 32'd6, 1'b1, 0);
    add_op(mdu_pkg::MDU_MUL,  1'b1, -32'sd3, 32'd5, 1'b1, 0);
    add_op(mdu_pkg::MDU_MULH, 1'b1, 32'h8000_0000, 32'h8000_0000, 1'b1, 0);  // neg x neg
    add_op(mdu_pkg::MDU_MULH, 1'b0, 32'hffff_ffff, 32'hffff_ffff, 1'b1, 3);
    add_op(mdu_pkg::MDU_MULH, 1'b1, 32'hffff_ffff, 32'd2, 1'b0, 0);
    add_op(mdu_pkg::MDU_MUL,  1'b1, -32'sd7, -32'sd9, 1'b1, 0);
    add_op(mdu_pkg::MDU_DIV,  1'b0, 32'd100, 32'd7, 1'b1, 0);
    add_op(mdu_pkg::MDU_DIV,  1'b1, -32'sd100, 32'd7, 1'b1, 5);
    add_op(mdu_pkg::MDU_MOD,  1'b1, -32'sd100, 32'd7, 1'b1, 0);
    add_op(mdu_pkg::MDU_MOD,  1'b1, 32'd100, -32'sd7, 1'b1, 0);
    add_op(mdu_pkg::MDU_DIV,  1'b0, 32'hffff_ffff, 32'd3, 1'b1, 0);
    add_op(mdu_pkg::MDU_DIV,  1'b1, 32'd1234, 32'd0, 1'b1, 0);   // divide by zero
    add_op(mdu_pkg::MDU_MOD,  1'b0, 32'd1234, 32'd0, 1'b1, 2);
    add_op(mdu_pkg::MDU_DIV,  1'b1, 32'h8000_0000, 32'hffff_ffff, 1'b1, 0);  // overflow
    add_op(mdu_pkg::MDU_MOD,  1'b1, 32'h8000_0000, 32'hffff_ffff, 1'b1, 0);
    for (int i = 0; i < 8; i++) begin
      add_op(mdu_pkg::mdu_op_e'($random(seed)), $random(seed), $random(seed),
             $random(seed), 1'b1, (i % 3 == 0) ? 2 : 0);
    end

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    foreach (table_q[i]) begin
      if (aborted) break;
      issue(table_q[i]);
      if (table_q[i].stall != 0 && !aborted) stall_wb(table_q[i].stall);
    end

    // flush a divide, then a plain op must follow cleanly
    if (!aborted) begin
      issue('{mdu_pkg::MDU_DIV, 1'b1, 32'd999, 32'd5, 1'b1, 8'd0});
      repeat (10) @(posedge clk);
      @(negedge clk);
      flush_i = 1'b1;
      @(negedge clk);
      flush_i = 1'b0;
      issue('{mdu_pkg::MDU_MUL, 1'b0, 32'd11, 32'd13, 1'b0, 8'd0});
    end

    n = 0;
    while (pending != 0 && n < 100 && !aborted) begin
      @(posedge clk);
      n++;
    end
    if (n >= 100) begin
      $display("timeout: results still pending at the end of the run");
      aborted = 1'b1;
    end
    repeat (5) @(posedge clk);

    $display("summary: %0d tests, %0d errors, %0d pending", test_cnt, err_cnt, pending);
    if (!aborted && err_cnt == 0 && pending == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+src
src/mdu_pkg.sv
src/mdu_multiplier.sv
src/mdu_divider.sv
src/mdu_pipe.sv
src/mdu_top.sv
bench/mdu_sva.sv
bench/mdu_checker.sv
bench/mdu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mdu_tb -f flist.f -o mdu_sim
./obj_dir/mdu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
grep -q "TEST PASS" sim.log
